/* fpFmtPkg.sv */
// floating point format definitions
`default_nettype none

package fpFmtPkg;

  ////////////////////
  // field widths
  ////////////////////

  localparam int expBits     = 11;  // double exponent
  localparam int fracBits    = 52;  // double fraction
  localparam int sglFracBits = 23;  // single fraction
  localparam int normBits    = 56;  // fraction + guard + round + 2 sticky positions

  // bit positions inside the normalized fraction
  localparam int dblLsbPos = normBits - fracBits;     // double lsb, bit 4
  localparam int sglLsbPos = normBits - sglFracBits;  // single lsb, bit 33

  ////////////////////
  // types
  ////////////////////

  typedef logic [0:0]            fmtT;       // 0 single, 1 double
  typedef logic [expBits+1:0]    extExpT;    // exponent plus overflow and sign bits
  typedef logic [normBits-1:0]   normFracT;  // normalized fraction from the shifter
  typedef logic [fracBits-1:0]   fracT;      // result fraction

  // format codes
  localparam fmtT fmtSingle = 1'b0;
  localparam fmtT fmtDouble = 1'b1;

endpackage

`default_nettype wire

/* roundCtlPkg.sv */
// rounding control definitions
`default_nettype none

package roundCtlPkg;

  typedef logic [2:0] frmT;  // rounding mode field

  ////////////////////
  // rounding modes
  ////////////////////

  localparam frmT rmNearEven = 3'd0;  // nearest, ties to even
  localparam frmT rmToZero   = 3'd1;  // truncate
  localparam frmT rmDown     = 3'd2;  // toward -inf
  localparam frmT rmUp       = 3'd3;  // toward +inf
  localparam frmT rmNearMax  = 3'd4;  // nearest, ties away from zero

  // codes 5..7 are reserved and round like rmToZero

endpackage

`default_nettype wire

/* roundDecode.sv */
// rounder decode stage
`timescale 1ns/1ps
`default_nettype none

module roundDecode import fpFmtPkg::*, roundCtlPkg::*; (
  input  logic     clk,
  input  logic     rstN,
  // upstream link
  input  logic     inValid,
  output logic     inReady,
  input  logic     inSign,     // normalized sign
  input  fmtT      inFmt,      // output format
  input  frmT      inFrm,      // rounding mode
  input  extExpT   inExp,      // exponent, bit 12 set on underflow shift
  input  normFracT inFrac,     // normalized fraction
  input  logic     inSticky,   // sticky from addend / remainder
  // downstream link
  output logic     decValid,
  input  logic     decReady,
  output logic     decSign,
  output fmtT      decFmt,
  output frmT      decFrm,
  output extExpT   decExp,
  output fracT     decFrac,    // trimmed to double width
  output logic     decLsb,
  output logic     decGuard,
  output logic     decRound,
  output logic     decSticky
);

  logic isDbl;      // double selected
  logic lsbBit;     // lsb of the selected format
  logic guardBit;   // first bit below lsb
  logic roundBit;   // second bit below lsb
  logic dblTail;    // bits below the double round bit
  logic sglTail;    // bits between single round and double round (inclusive)
  logic stickyBit;  // combined sticky

  assign isDbl = (inFmt == fmtDouble);

  ////////////////////
  // bit extraction
  ////////////////////

  assign lsbBit   = isDbl ? inFrac[dblLsbPos]   : inFrac[sglLsbPos];
  assign guardBit = isDbl ? inFrac[dblLsbPos-1] : inFrac[sglLsbPos-1];
  assign roundBit = isDbl ? inFrac[dblLsbPos-2] : inFrac[sglLsbPos-2];

  // sticky reduction
  // double only looks at the two lowest positions, single at everything below its round bit
  assign dblTail = |inFrac[dblLsbPos-3:0];
  assign sglTail = |inFrac[sglLsbPos-3:dblLsbPos-2];

  // exponent bit 12 means the shifter went past underflow and dropped bits
  assign stickyBit = inSticky | dblTail | (sglTail & ~isDbl) | inExp[expBits+1];

  ////////////////////
  // stage register
  ////////////////////

  assign inReady = ~decValid | decReady;  // empty or draining

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      decValid <= 1'b0;
    end else if (inReady) begin
      decValid <= inValid;
    end
  end

  // payload, loads only on a transfer
  always_ff @(posedge clk) begin
    if (inValid && inReady) begin
      decSign   <= inSign;
      decFmt    <= inFmt;
      decFrm    <= inFrm;
      decExp    <= inExp;
      decFrac   <= inFrac[normBits-1 -: fracBits];  // top bits are the double fraction
      decLsb    <= lsbBit;
      decGuard  <= guardBit;
      decRound  <= roundBit;
      decSticky <= stickyBit;
    end
  end

endmodule

`default_nettype wire

/* roundExec.sv */
// rounder increment decision stage
`timescale 1ns/1ps
`default_nettype none

module roundExec import fpFmtPkg::*, roundCtlPkg::*; (
  input  logic   clk,
  input  logic   rstN,
  // upstream link
  input  logic   decValid,
  output logic   decReady,
  input  logic   decSign,
  input  fmtT    decFmt,
  input  frmT    decFrm,
  input  extExpT decExp,
  input  fracT   decFrac,
  input  logic   decLsb,
  input  logic   decGuard,
  input  logic   decRound,
  input  logic   decSticky,
  // downstream link
  output logic   exeValid,
  input  logic   exeReady,
  output logic   exeSign,
  output fmtT    exeFmt,
  output extExpT exeExp,
  output fracT   exeFrac,
  output logic   exeGuard,
  output logic   exeRound,
  output logic   exeSticky,
  output logic   exePlus1   // add one at the format lsb
);

  logic calcPlus1;  // raw increment from the mode
  logic inexact;    // any bit lost below lsb
  logic plus1;

  // increment per rounding mode
  always_comb begin
    case (decFrm)
      rmNearEven: calcPlus1 = decGuard & (decRound | decSticky | decLsb);  // ties to even
      rmToZero:   calcPlus1 = 1'b0;
      rmDown:     calcPlus1 = decSign;   // negative grows in magnitude
      rmUp:       calcPlus1 = ~decSign;  // positive grows in magnitude
      rmNearMax:  calcPlus1 = decGuard;  // ties away
      default:    calcPlus1 = 1'b0;      // reserved codes truncate
    endcase
  end

  // exact results never round
  assign inexact = decGuard | decRound | decSticky;
  assign plus1   = calcPlus1 & inexact;

  ////////////////////
  // stage register
  ////////////////////

  assign decReady = ~exeValid | exeReady;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      exeValid <= 1'b0;
    end else if (decReady) begin
      exeValid <= decValid;
    end
  end

  always_ff @(posedge clk) begin
    if (decValid && decReady) begin
      exeSign   <= decSign;
      exeFmt    <= decFmt;
      exeExp    <= decExp;
      exeFrac   <= decFrac;
      exeGuard  <= decGuard;
      exeRound  <= decRound;
      exeSticky <= decSticky;
      exePlus1  <= plus1;
    end
  end

endmodule

`default_nettype wire

/* roundResult.sv */
// rounder result stage
`timescale 1ns/1ps
`default_nettype none

module roundResult import fpFmtPkg::*; (
  input  logic   clk,
  input  logic   rstN,
  // upstream link
  input  logic   exeValid,
  output logic   exeReady,
  input  logic   exeSign,
  input  fmtT    exeFmt,
  input  extExpT exeExp,
  input  fracT   exeFrac,
  input  logic   exeGuard,
  input  logic   exeRound,
  input  logic   exeSticky,
  input  logic   exePlus1,
  // result link
  output logic   outValid,
  input  logic   outReady,
  output logic   outSign,
  output extExpT outExp,    // full exponent, receiver slices what it needs
  output fracT   outFrac,
  output logic   outGuard,
  output logic   outRound,
  output logic   outSticky,
  output logic   outPlus1
);

  logic                      isSgl;
  logic [expBits+fracBits+1:0] roundAdd;  // increment lined up with {exp, frac}
  extExpT                    sumExp;
  fracT                      sumFrac;

  assign isSgl = (exeFmt == fmtSingle);

  ////////////////////
  // increment
  ////////////////////

  // single lsb sits at fraction bit fracBits-sglFracBits, double lsb at bit 0
  assign roundAdd = {{(expBits+1+sglFracBits){1'b0}}, exePlus1 & isSgl,
                     {(fracBits-sglFracBits-1){1'b0}}, exePlus1 & ~isSgl};

  // fraction overflow ripples into the exponent
  assign {sumExp, sumFrac} = {exeExp, exeFrac} + roundAdd;

  ////////////////////
  // stage register
  ////////////////////

  assign exeReady = ~outValid | outReady;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      outValid <= 1'b0;
    end else if (exeReady) begin
      outValid <= exeValid;
    end
  end

  always_ff @(posedge clk) begin
    if (exeValid && exeReady) begin
      outSign   <= exeSign;
      outExp    <= sumExp;
      outFrac   <= sumFrac;   // low bits below single lsb unchanged
      outGuard  <= exeGuard;
      outRound  <= exeRound;
      outSticky <= exeSticky;
      outPlus1  <= exePlus1;
    end
  end

endmodule

`default_nettype wire

/* fpRounder.sv */
// pipelined floating point rounder
`timescale 1ns/1ps
`default_nettype none

module fpRounder import fpFmtPkg::*, roundCtlPkg::*; (
  input  logic     clk,
  input  logic     rstN,
  input  logic     inValid,
  output logic     inReady,
  input  logic     inSign,
  input  fmtT      inFmt,
  input  frmT      inFrm,
  input  extExpT   inExp,
  input  normFracT inFrac,
  input  logic     inSticky,
  output logic     outValid,
  input  logic     outReady,
  output logic     outSign,
  output extExpT   outExp,
  output fracT     outFrac,
  output logic     outGuard,
  output logic     outRound,
  output logic     outSticky,
  output logic     outPlus1
);

  // decode -> exec
  logic   decValid, decReady, decSign;
  fmtT    decFmt;
  frmT    decFrm;
  extExpT decExp;
  fracT   decFrac;
  logic   decLsb, decGuard, decRound, decSticky;

  // exec -> result
  logic   exeValid, exeReady, exeSign;
  fmtT    exeFmt;
  extExpT exeExp;
  fracT   exeFrac;
  logic   exeGuard, exeRound, exeSticky, exePlus1;

  roundDecode decode_i (
    .clk, .rstN,
    .inValid, .inReady, .inSign, .inFmt, .inFrm, .inExp, .inFrac, .inSticky,
    .decValid, .decReady, .decSign, .decFmt, .decFrm, .decExp, .decFrac,
    .decLsb, .decGuard, .decRound, .decSticky
  );

  roundExec exec_i (
    .clk, .rstN,
    .decValid, .decReady, .decSign, .decFmt, .decFrm, .decExp, .decFrac,
    .decLsb, .decGuard, .decRound, .decSticky,
    .exeValid, .exeReady, .exeSign, .exeFmt, .exeExp, .exeFrac,
    .exeGuard, .exeRound, .exeSticky, .exePlus1
  );

  roundResult result_i (
    .clk, .rstN,
    .exeValid, .exeReady, .exeSign, .exeFmt, .exeExp, .exeFrac,
    .exeGuard, .exeRound, .exeSticky, .exePlus1,
    .outValid, .outReady, .outSign, .outExp, .outFrac,
    .outGuard, .outRound, .outSticky, .outPlus1
  );

endmodule

`default_nettype wire

/* fpRounder_asserts.sv */
// rounder handshake assertions
`timescale 1ns/1ps
`default_nettype none

module fpRounder_asserts import fpFmtPkg::*; (
  input logic   clk,
  input logic   rstN,
  input logic   inReady,
  input logic   outValid,
  input logic   outReady,
  input logic   outSign,
  input extExpT outExp,
  input fracT   outFrac,
  input logic   outGuard,
  input logic   outRound,
  input logic   outSticky,
  input logic   outPlus1
);

  // nothing leaves while held in reset
  resetQuiet: assert property (@(posedge clk) !rstN |-> !outValid)
    else $error("outValid high during reset");

  // stalled result keeps valid and data
  holdOnStall: assert property (@(posedge clk) disable iff (!rstN)
    outValid && !outReady |=> outValid && $stable(outSign) && $stable(outExp)
      && $stable(outFrac) && $stable(outGuard) && $stable(outRound)
      && $stable(outSticky) && $stable(outPlus1))
    else $error("output changed while stalled");

  readyAfterReset: assert property (@(posedge clk) $rose(rstN) |-> inReady)
    else $error("inReady low right after reset");  // pipe is empty

endmodule

bind fpRounder fpRounder_asserts asserts_i (
  .clk(clk), .rstN(rstN), .inReady(inReady), .outValid(outValid), .outReady(outReady),
  .outSign(outSign), .outExp(outExp), .outFrac(outFrac), .outGuard(outGuard),
  .outRound(outRound), .outSticky(outSticky), .outPlus1(outPlus1)
);

`default_nettype wire

/* fpRounder_tb.sv */
// fp rounder testbench
`timescale 1ns/1ps
`default_nettype none

module fpRounder_tb import fpFmtPkg::*, roundCtlPkg::*; ();

  localparam int itemsPerPhase = 400;
  localparam int timeoutCycles = 1000;
  localparam int latencyCycles = 3;   // accepting edge to output edge
  localparam int numPhases     = 5;

  logic     clk;
  logic     rstN;
  logic     inValid, inReady, inSign, inSticky;
  fmtT      inFmt;
  frmT      inFrm;
  extExpT   inExp;
  normFracT inFrac;
  logic     outValid, outReady, outSign, outGuard, outRound, outSticky, outPlus1;
  extExpT   outExp;
  fracT     outFrac;

  logic [31:0] rngState = 32'hbacd;
  int          phase = 0;
  bit          backPressure = 1'b0;
  int          cycleCount = 0;
  int          sentCount = 0;
  int          recvCount = 0;
  logic [69:0] expQ[$];     // {sign, exp, frac, guard, round, sticky, plus1}
  int          phaseQ[$];
  int          acceptQ[$];  // cycle of the input transfer
  string       phaseName[numPhases] = '{"double", "single", "carry", "exact", "backpressure"};

  fpRounder dut_i (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) cycleCount <= cycleCount + 1;

  ////////////////////
  // helpers
  ////////////////////

  function automatic logic [31:0] nextRand();
    rngState ^= rngState << 13;
    rngState ^= rngState >> 17;
    rngState ^= rngState << 5;
    return rngState;
  endfunction

  // expected result straight from the rounding rules
  function automatic logic [69:0] roundModel(input logic sign, input fmtT fmt, input frmT frm,
                                            input extExpT exp, input normFracT frac,
                                            input logic extSticky);
    int lsbPos;
    int b;
    logic lsb, g, r, s, inc, p1;
    logic [expBits+fracBits+1:0] addend;
    logic [expBits+fracBits+1:0] sum;
    lsbPos = (fmt == fmtDouble) ? normBits - fracBits : normBits - sglFracBits;
    lsb = frac[lsbPos];
    g   = frac[lsbPos-1];
    r   = frac[lsbPos-2];
    s   = extSticky | exp[expBits+1];  // underflow shift counts as inexact
    for (b = 0; b < lsbPos - 2; b++) s = s | frac[b];
    case (frm)
      rmNearEven: inc = g & (r | s | lsb);
      rmDown:     inc = sign;
      rmUp:       inc = ~sign;
      rmNearMax:  inc = g;
      default:    inc = 1'b0;  // toward zero and codes 5..7
    endcase
    p1 = inc & (g | r | s);
    addend = '0;
    addend[lsbPos - (normBits - fracBits)] = p1;  // one at the format lsb
    sum = {exp, frac[normBits-1 -: fracBits]} + addend;
    return {sign, sum, g, r, s, p1};
  endfunction

  task automatic abortRun(input string reason);
    $display("%s", reason);
    $display("Regression failed");
    $fatal(1, "run stopped");
  endtask

  task automatic checkValue(input string testName, input string field,
                            input logic [63:0] expVal, input logic [63:0] actVal);
    if (expVal !== actVal)
      abortRun($sformatf("[FAIL] %s %s expected %0h actual %0h", testName, field, expVal, actVal));
  endtask

  ////////////////////
  // stimulus
  ////////////////////

  task automatic makeItem(input int ph);
    logic [63:0] wide;
    logic [31:0] r;
    wide     = {nextRand(), nextRand()};
    r        = nextRand();
    inSign   = r[0];
    inFmt    = (ph == 0) ? fmtDouble : (ph == 1) ? fmtSingle : r[1];
    inFrm    = r[4:2];                         // all eight codes
    inExp    = {(r[7:5] == 3'd0), r[20:9]};    // bit 12 now and then
    inSticky = (r[22:21] == 2'd0);
    inFrac   = wide[normBits-1:0];
    case (ph)
      2: begin  // ones from guard upward, so a round up carries out
        if (inFmt == fmtDouble) inFrac[normBits-1:normBits-fracBits-1] = '1;
        else inFrac[normBits-1:normBits-sglFracBits-1] = '1;
        inFrm = r[23] ? rmNearMax : rmUp;
        if (inFrm == rmUp) inSign = 1'b0;
      end
      3: begin  // exact value, nothing below the lsb
        inSticky = 1'b0;
        inExp[expBits+1] = 1'b0;
        if (inFmt == fmtDouble) inFrac[normBits-fracBits-1:0] = '0;
        else inFrac[normBits-sglFracBits-1:0] = '0;
      end
      default: ;
    endcase
  endtask

  task automatic waitAccept();
    int waited;
    waited = 0;
    @(negedge clk);
    while (!inReady) begin
      if (waited >= timeoutCycles) abortRun("timeout: input was never accepted");
      waited++;
      @(negedge clk);
    end
    @(posedge clk);  // transfer edge
    #1;
  endtask

  task automatic drainPipe();
    int waited;
    waited = 0;
    while (expQ.size() != 0) begin
      if (waited >= timeoutCycles) abortRun("timeout: pipeline did not drain");
      waited++;
      @(posedge clk);
    end
    @(posedge clk);
    #1;
  endtask

  // sink side, random stalls only in the back-pressure phase
  initial begin
    forever begin
      @(posedge clk);
      #1;
      outReady = backPressure ? (nextRand() % 3 != 0) : 1'b1;
    end
  end

  ////////////////////
  // scoreboard
  ////////////////////

  always @(negedge clk) begin
    if (rstN && inValid && inReady) begin
      expQ.push_back(roundModel(inSign, inFmt, inFrm, inExp, inFrac, inSticky));
      phaseQ.push_back(phase);
      acceptQ.push_back(cycleCount);
      sentCount++;
    end
  end

  always @(negedge clk) begin : outMon
    logic [69:0] expVal;
    int          ph;
    int          acc;
    if (rstN && outValid) begin
      if (expQ.size() == 0) abortRun("outValid high with no item in flight");
      if (outReady) begin
        expVal = expQ.pop_front();
        ph     = phaseQ.pop_front();
        acc    = acceptQ.pop_front();
        recvCount++;
        checkValue(phaseName[ph], "outSign",   expVal[69],    outSign);
        checkValue(phaseName[ph], "outExp",    expVal[68:56], outExp);
        checkValue(phaseName[ph], "outFrac",   expVal[55:4],  outFrac);
        checkValue(phaseName[ph], "outGuard",  expVal[3],     outGuard);
        checkValue(phaseName[ph], "outRound",  expVal[2],     outRound);
        checkValue(phaseName[ph], "outSticky", expVal[1],     outSticky);
        checkValue(phaseName[ph], "outPlus1",  expVal[0],     outPlus1);
        if (ph != 4) checkValue(phaseName[ph], "latency", latencyCycles, cycleCount - acc);
      end
    end
  end

  ////////////////////
  // main sequence
  ////////////////////

  initial begin
    int p;
    int n;
    int idle;
    logic [31:0] r;
    rstN     = 1'b0;
    inValid  = 1'b0;
    inSign   = 1'b0;
    inFmt    = fmtDouble;
    inFrm    = rmNearEven;
    inExp    = '0;
    inFrac   = '0;
    inSticky = 1'b0;
    outReady = 1'b1;
    repeat (4) @(posedge clk);
    #1;
    rstN = 1'b1;
    for (p = 0; p < numPhases; p++) begin
      phase        = p;
      backPressure = (p == 4);
      @(posedge clk);
      #1;
      for (n = 0; n < itemsPerPhase; n++) begin
        r    = nextRand();
        idle = (r[1:0] == 2'd0) ? 1 + int'(r[5:4]) : 0;  // mostly back to back
        repeat (idle) begin
          inValid = 1'b0;
          @(posedge clk);
          #1;
        end
        makeItem(p);
        inValid = 1'b1;
        waitAccept();
      end
      inValid = 1'b0;
      drainPipe();
    end
    if (recvCount == sentCount && sentCount == numPhases * itemsPerPhase) begin
      $display("Regression passed");
      $finish;
    end else begin
      abortRun($sformatf("item count wrong: sent %0d received %0d", sentCount, recvCount));
    end
  end

endmodule

`default_nettype wire

/* fpRounder.f */
fpFmtPkg.sv
roundCtlPkg.sv
roundDecode.sv
roundExec.sv
roundResult.sv
fpRounder.sv
fpRounder_asserts.sv
fpRounder_tb.sv

/* run.sh */
#!/bin/sh
# build and run the rounder testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal \
  --top-module fpRounder_tb \
  -f fpRounder.f \
  -o fpRounderSim

./obj_dir/fpRounderSim
